//--- common/mesh_route_consts.svh
`ifndef MESH_ROUTE_CONSTS_SVH
`define MESH_ROUTE_CONSTS_SVH

// mesh dimensions
`define MESH_NX 4 // columns
`define MESH_NY 4 // rows

// coordinate widths follow the mesh size
`define MESH_XW ($clog2(`MESH_NX))
`define MESH_YW ($clog2(`MESH_NY))

// a mesh router always has local plus four neighbours
`define MESH_PORTS 5

// destination code is x, y, a, b
`define ROUTE_CODE_W 4

`endif

//--- common/mesh_route_pkg.sv
`default_nettype none

`include "mesh_route_consts.svh"

package mesh_route_pkg;

    // port index, also the bit position in a mask
    typedef enum logic [2:0] {
        LOCAL = 3'd0,
        EAST  = 3'd1,
        NORTH = 3'd2,
        WEST  = 3'd3,
        SOUTH = 3'd4
    } port_e;

    // algorithm opcode
    typedef enum logic [1:0] {
        ALGO_XY         = 2'd0,
        ALGO_WEST_FIRST = 2'd1,
        ALGO_ODD_EVEN   = 2'd2,
        ALGO_DUATO      = 2'd3
    } route_algo_e;

    // one bit per permitted output port
    typedef logic [`MESH_PORTS-1:0] port_mask_t;

    // {x, y, a, b} from msb down
    typedef logic [`ROUTE_CODE_W-1:0] route_code_t;

endpackage

`default_nettype wire

//--- common/mesh_coord_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "mesh_route_consts.svh"

interface mesh_coord_if;

    logic [`MESH_XW-1:0] current_x; // router column
    logic [`MESH_YW-1:0] current_y; // router row
    logic [`MESH_XW-1:0] dest_x;    // destination column
    logic [`MESH_YW-1:0] dest_y;    // destination row

    modport src (
        output current_x, current_y, dest_x, dest_y
    );

    modport sink (
        input current_x, current_y, dest_x, dest_y
    );

endinterface

`default_nettype wire

//--- common/mesh_dir_if.sv
`timescale 1ns/1ps
`default_nettype none

interface mesh_dir_if;

    logic x_plus; // destination is east
    logic x_min;  // destination is west
    logic y_plus; // destination is south
    logic y_min;  // destination is north
    logic same_x;
    logic same_y;

    modport src (
        output x_plus, x_min, y_plus, y_min, same_x, same_y
    );

    modport sink (
        input x_plus, x_min, y_plus, y_min, same_x, same_y
    );

endinterface

`default_nettype wire

//--- verilog/mesh_dir.sv
`timescale 1ns/1ps
`default_nettype none

`include "mesh_route_consts.svh"

module mesh_dir (
    mesh_coord_if.sink coord,
    mesh_dir_if.src    dir
);

    // one extra bit so the difference keeps its sign
    logic signed [`MESH_XW:0] xc;
    logic signed [`MESH_XW:0] xd;
    logic signed [`MESH_XW:0] xdiff;
    logic signed [`MESH_YW:0] yc;
    logic signed [`MESH_YW:0] yd;
    logic signed [`MESH_YW:0] ydiff;

    assign xc = {1'b0, coord.current_x};
    assign xd = {1'b0, coord.dest_x};
    assign yc = {1'b0, coord.current_y};
    assign yd = {1'b0, coord.dest_y};

    assign xdiff = xd - xc; // positive when heading east
    assign ydiff = yd - yc; // positive when heading south

    assign dir.x_plus = (xdiff > 0);
    assign dir.x_min  = (xdiff < 0);
    assign dir.y_plus = (ydiff > 0);
    assign dir.y_min  = (ydiff < 0);
    assign dir.same_x = (xdiff == 0);
    assign dir.same_y = (ydiff == 0);

endmodule

`default_nettype wire

//--- routing/xy_routing.sv
`timescale 1ns/1ps
`default_nettype none

module xy_routing
    import mesh_route_pkg::*;
(
    mesh_dir_if.sink dir,
    output port_mask_t port_mask
);

    // dimension order, x is finished before y starts
    always_comb begin
        port_mask = '0;
        if (dir.x_plus) begin
            port_mask[EAST] = 1'b1;
        end
        else if (dir.x_min) begin
            port_mask[WEST] = 1'b1;
        end
        else if (dir.y_plus) begin
            port_mask[SOUTH] = 1'b1; // column reached, go down
        end
        else if (dir.y_min) begin
            port_mask[NORTH] = 1'b1;
        end
        else begin
            port_mask[LOCAL] = 1'b1; // arrived
        end
    end

endmodule

`default_nettype wire

//--- routing/west_first_routing.sv
`timescale 1ns/1ps
`default_nettype none

module west_first_routing
    import mesh_route_pkg::*;
(
    mesh_dir_if.sink dir,
    output port_mask_t port_mask
);

    // Turns into the west are forbidden, so any westward hop has to be
    // taken first and alone. Once no west hop is left the packet may
    // pick freely between east and the vertical direction.
    always_comb begin
        port_mask = '0;
        if (dir.same_x && dir.same_y) begin
            port_mask[LOCAL] = 1'b1;
        end
        else if (dir.x_min) begin
            port_mask[WEST] = 1'b1; // no adaptivity while westbound
        end
        else if (dir.x_plus && dir.y_min) begin
            port_mask[EAST]  = 1'b1;
            port_mask[NORTH] = 1'b1;
        end
        else if (dir.x_plus && dir.y_plus) begin
            port_mask[EAST]  = 1'b1;
            port_mask[SOUTH] = 1'b1;
        end
        else if (dir.x_plus && dir.same_y) begin
            port_mask[EAST] = 1'b1;
        end
        else if (dir.same_x && dir.y_min) begin
            port_mask[NORTH] = 1'b1;
        end
        else if (dir.same_x && dir.y_plus) begin
            port_mask[SOUTH] = 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- routing/odd_even_routing.sv
`timescale 1ns/1ps
`default_nettype none

`include "mesh_route_consts.svh"

module odd_even_routing
    import mesh_route_pkg::*;
#(
    parameter int LOCATED_IN_NI = 1 // 1: routing done in the NI, 0: inside the router
)
(
    mesh_coord_if.sink coord,
    mesh_dir_if.sink   dir,
    output port_mask_t port_mask
);

    logic [`MESH_XW-1:0] x_dist;    // only meaningful when eastbound
    port_e               vert_port; // vertical port toward the destination
    logic                cur_odd;
    logic                dst_odd;

    assign x_dist    = coord.dest_x - coord.current_x;
    assign vert_port = dir.y_min ? NORTH : SOUTH;
    assign cur_odd   = coord.current_x[0];
    assign dst_odd   = coord.dest_x[0];

    // Odd-even turn model. East-north and east-south turns are not taken
    // in even columns, north-west and south-west turns not in odd ones.
    always_comb begin
        port_mask = '0;
        if (dir.same_x && dir.same_y) begin
            port_mask[LOCAL] = 1'b1;
        end
        else if (dir.same_x) begin
            port_mask[vert_port] = 1'b1; // same column, straight up or down
        end
        else if (dir.same_y) begin
            if (dir.x_min) begin
                port_mask[WEST] = 1'b1;
            end
            else begin
                port_mask[EAST] = 1'b1;
            end
        end
        else if (dir.x_plus) begin
            // vertical hop allowed in odd columns or at the source NI
            if (cur_odd || (LOCATED_IN_NI == 1)) begin
                port_mask[vert_port] = 1'b1;
            end
            // an even destination column one step away must be entered
            // from its own column, not by turning there
            if (dst_odd || (x_dist != 1)) begin
                port_mask[EAST] = 1'b1;
            end
        end
        else begin
            port_mask[WEST] = 1'b1; // westbound
            if (!cur_odd) begin
                port_mask[vert_port] = 1'b1; // even column
            end
        end
    end

endmodule

`default_nettype wire

//--- routing/duato_routing.sv
`timescale 1ns/1ps
`default_nettype none

module duato_routing
    import mesh_route_pkg::*;
(
    mesh_dir_if.sink dir,
    output port_mask_t port_mask
);

    logic x_done;
    logic y_done;

    assign x_done = dir.same_x;
    assign y_done = dir.same_y;

    // Fully adaptive minimal routing. Deadlock freedom relies on the
    // escape VC in the router, so every productive port is offered here.
    always_comb begin
        port_mask = '0;
        if (x_done && y_done) begin
            port_mask[LOCAL] = 1'b1;
        end
        else begin
            // x direction toward the destination
            if (dir.x_plus) begin
                port_mask[EAST] = 1'b1;
            end
            else if (dir.x_min) begin
                port_mask[WEST] = 1'b1;
            end

            // y direction toward the destination
            if (dir.y_plus) begin
                port_mask[SOUTH] = 1'b1;
            end
            else if (dir.y_min) begin
                port_mask[NORTH] = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/mesh_route_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "mesh_route_consts.svh"

module mesh_route_unit
    import mesh_route_pkg::*;
#(
    parameter int LOCATED_IN_NI = 1
)
(
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                in_valid,
    input  wire route_algo_e         algo,
    input  wire logic [`MESH_XW-1:0] current_x,
    input  wire logic [`MESH_YW-1:0] current_y,
    input  wire logic [`MESH_XW-1:0] dest_x,
    input  wire logic [`MESH_YW-1:0] dest_y,
    output logic                     out_valid,
    output port_mask_t               route_mask,
    output route_code_t              route_code
);

    mesh_coord_if coord_bus ();
    mesh_dir_if   dir_bus ();

    port_mask_t  xy_mask;
    port_mask_t  wf_mask;
    port_mask_t  oe_mask;
    port_mask_t  duato_mask;
    port_mask_t  sel_mask;
    route_code_t sel_code;

    // inputs go straight onto the coordinate bus
    assign coord_bus.current_x = current_x;
    assign coord_bus.current_y = current_y;
    assign coord_bus.dest_x    = dest_x;
    assign coord_bus.dest_y    = dest_y;

    mesh_dir u_dir (
        .coord (coord_bus.sink),
        .dir   (dir_bus.src)
    );

    xy_routing u_xy (
        .dir       (dir_bus.sink),
        .port_mask (xy_mask)
    );

    west_first_routing u_wf (
        .dir       (dir_bus.sink),
        .port_mask (wf_mask)
    );

    odd_even_routing #(
        .LOCATED_IN_NI (LOCATED_IN_NI)
    ) u_oe (
        .coord     (coord_bus.sink),
        .dir       (dir_bus.sink),
        .port_mask (oe_mask)
    );

    duato_routing u_duato (
        .dir       (dir_bus.sink),
        .port_mask (duato_mask)
    );

    always_comb begin
        sel_mask = xy_mask;
        case (algo)
            ALGO_XY:         sel_mask = xy_mask;
            ALGO_WEST_FIRST: sel_mask = wf_mask;
            ALGO_ODD_EVEN:   sel_mask = oe_mask;
            ALGO_DUATO:      sel_mask = duato_mask;
            default:         sel_mask = xy_mask;
        endcase
    end

    // code: x = eastbound, y = northbound, a = horizontal hop, b = vertical hop
    assign sel_code = {dir_bus.x_plus,
                       dir_bus.y_min,
                       sel_mask[EAST] | sel_mask[WEST],
                       sel_mask[NORTH] | sel_mask[SOUTH]};

    // result stage, one cycle after the request
    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid  <= 1'b0;
            route_mask <= '0;
            route_code <= '0;
        end
        else begin
            out_valid <= in_valid;
            if (in_valid) begin
                route_mask <= sel_mask;
                route_code <= sel_code;
            end
        end
    end

endmodule

`default_nettype wire

//--- tests/mesh_route_model.svh
`ifndef MESH_ROUTE_MODEL_SVH
`define MESH_ROUTE_MODEL_SVH

// expected port mask for one request, one branch per algorithm
function automatic port_mask_t model_mask(input route_algo_e a, input int cx, input int cy,
                                          input int dx, input int dy, input int ni);
    int         ddx;
    int         ddy;
    port_e      h;
    port_e      v;
    port_mask_t m;
    ddx = dx - cx;
    ddy = dy - cy;
    h = (ddx > 0) ? EAST : WEST;
    v = (ddy < 0) ? NORTH : SOUTH; // positive y difference is south
    m = '0;
    if (ddx == 0 && ddy == 0) begin
        m[LOCAL] = 1'b1; // every algorithm ejects here
        return m;
    end
    case (a)
        ALGO_XY: begin
            if (ddx != 0) begin
                m[h] = 1'b1;
            end
            else begin
                m[v] = 1'b1;
            end
        end
        ALGO_WEST_FIRST: begin
            if (ddx < 0) begin
                m[WEST] = 1'b1; // west hops go alone
            end
            else begin
                if (ddx > 0) m[EAST] = 1'b1;
                if (ddy != 0) m[v] = 1'b1;
            end
        end
        ALGO_ODD_EVEN: begin
            if (ddx == 0) begin
                m[v] = 1'b1;
            end
            else if (ddy == 0) begin
                m[h] = 1'b1;
            end
            else if (ddx > 0) begin
                if ((cx % 2) == 1 || ni == 1) m[v] = 1'b1;
                if ((dx % 2) == 1 || ddx != 1) m[EAST] = 1'b1;
            end
            else begin
                m[WEST] = 1'b1;
                if ((cx % 2) == 0) m[v] = 1'b1; // even column may turn
            end
        end
        default: begin
            if (ddx != 0) m[h] = 1'b1; // duato, all productive ports
            if (ddy != 0) m[v] = 1'b1;
        end
    endcase
    return m;
endfunction

// code bits {x, y, a, b}
function automatic route_code_t model_code(input int cx, input int cy, input int dx,
                                           input int dy, input port_mask_t m);
    return {dx > cx, dy < cy, m[EAST] | m[WEST], m[NORTH] | m[SOUTH]};
endfunction

`endif

//--- tests/tb_mesh_route.sv
`timescale 1ns/1ps
`default_nettype none

`include "mesh_route_consts.svh"

module tb_mesh_route
    import mesh_route_pkg::*;
();

    `include "mesh_route_model.svh"

    typedef struct packed {
        route_algo_e       algo;
        logic signed [3:0] ddx;
        logic signed [3:0] ddy;
        logic              cx_odd;
        port_mask_t        mask;
        route_code_t       code;
    } expect_t;

    logic                clk;
    logic                rst;
    logic                in_valid;
    route_algo_e         algo;
    logic [`MESH_XW-1:0] current_x;
    logic [`MESH_YW-1:0] current_y;
    logic [`MESH_XW-1:0] dest_x;
    logic [`MESH_YW-1:0] dest_y;
    logic                out_valid;
    port_mask_t          route_mask;
    route_code_t         route_code;

    expect_t pending_q[$];
    logic    sent_prev; // request taken at the last edge
    int      errors;
    int      tests_ok;
    int      tests_bad;
    int      seed;
    int      mark;

    mesh_route_unit #(
        .LOCATED_IN_NI (1)
    ) dut0 (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .algo       (algo),
        .current_x  (current_x),
        .current_y  (current_y),
        .dest_x     (dest_x),
        .dest_y     (dest_y),
        .out_valid  (out_valid),
        .route_mask (route_mask),
        .route_code (route_code)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        sent_prev <= in_valid && !rst;
    end

    task automatic compare_field(input string name, input logic [4:0] exp, input logic [4:0] got);
        assert (got === exp) else begin
            $display("[FAIL] %s expected %h got %h", name, exp, got);
            errors++;
        end
    endtask

    // turn-model properties on top of the exact compare
    task automatic check_turn_rules(input expect_t e);
        if (e.algo == ALGO_WEST_FIRST && e.ddx < 0) begin
            assert (!route_mask[NORTH] && !route_mask[SOUTH]) else begin
                $display("[FAIL] route_mask %h turns on a west-first westbound hop", route_mask);
                errors++;
            end
        end
        if (e.algo == ALGO_ODD_EVEN && e.ddx < 0 && e.ddy != 0 && !e.cx_odd) begin
            assert ($countones(route_mask) == 2) else begin
                $display("[FAIL] route_mask %h should hold two ports", route_mask);
                errors++;
            end
        end
        if (e.algo == ALGO_ODD_EVEN && e.ddx == 1 && e.ddy != 0 && e.cx_odd) begin
            assert (!route_mask[EAST]) else begin
                $display("[FAIL] route_mask %h offers east into an even column", route_mask);
                errors++;
            end
        end
        if (e.algo == ALGO_DUATO && e.ddx == 0 && e.ddy == 0) begin
            compare_field("route_mask", 5'h01, route_mask);
            compare_field("route_code", 5'h00, route_code);
        end
    endtask

    // outputs are stable at the falling edge
    always @(negedge clk) begin : check_result
        expect_t e;
        compare_field("out_valid", sent_prev, out_valid); // exactly one cycle later
        if (out_valid === 1'b1) begin
            assert (pending_q.size() != 0) else begin
                $display("a result came out with no request pending");
                errors++;
            end
            if (pending_q.size() != 0) begin
                e = pending_q.pop_front();
                compare_field("route_mask", e.mask, route_mask);
                compare_field("route_code", e.code, route_code);
                check_turn_rules(e);
            end
        end
    end

    task automatic send(input route_algo_e a, input int cx, input int cy, input int dx,
                        input int dy);
        expect_t e;
        in_valid  = 1'b1;
        algo      = a;
        current_x = cx[`MESH_XW-1:0];
        current_y = cy[`MESH_YW-1:0];
        dest_x    = dx[`MESH_XW-1:0];
        dest_y    = dy[`MESH_YW-1:0];
        e.algo    = a;
        e.ddx     = 4'(dx - cx);
        e.ddy     = 4'(dy - cy);
        e.cx_odd  = (cx % 2) == 1;
        e.mask    = model_mask(a, cx, cy, dx, dy, 1);
        e.code    = model_code(cx, cy, dx, dy, e.mask);
        pending_q.push_back(e);
        @(posedge clk);
        #1;
    endtask

    task automatic send_random(input route_algo_e a);
        send(a, $unsigned($random(seed)) % `MESH_NX, $unsigned($random(seed)) % `MESH_NY,
             $unsigned($random(seed)) % `MESH_NX, $unsigned($random(seed)) % `MESH_NY);
    endtask

    task automatic send_all_pairs(input route_algo_e a);
        for (int cx = 0; cx < `MESH_NX; cx++)
            for (int cy = 0; cy < `MESH_NY; cy++)
                for (int dx = 0; dx < `MESH_NX; dx++)
                    for (int dy = 0; dy < `MESH_NY; dy++)
                        send(a, cx, cy, dx, dy);
    endtask

    task automatic idle();
        in_valid = 1'b0;
        @(posedge clk);
        #1;
    endtask

    task automatic drain();
        int n;
        in_valid = 1'b0;
        n = 0;
        while (pending_q.size() != 0 && n < 10) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (pending_q.size() != 0) begin
            $display("timed out waiting for %0d results", pending_q.size());
            errors++;
            pending_q.delete();
        end
    endtask

    task automatic finish_test(input string name);
        if (errors == mark) begin
            $display("[test] %s: ok", name);
            tests_ok++;
        end
        else begin
            $display("[test] %s: %0d errors", name, errors - mark);
            tests_bad++;
        end
        mark = errors;
    endtask

    initial begin
        clk       = 1'b0;
        rst       = 1'b1;
        in_valid  = 1'b0;
        algo      = ALGO_XY;
        current_x = '0;
        current_y = '0;
        dest_x    = '0;
        dest_y    = '0;
        errors    = 0;
        tests_ok  = 0;
        tests_bad = 0;
        mark      = 0;
        seed      = 87199;

        repeat (3) begin
            @(posedge clk);
            #1;
            compare_field("out_valid", 1'b0, out_valid);
            compare_field("route_mask", '0, route_mask);
            compare_field("route_code", '0, route_code);
            in_valid = 1'b1; // ignored while rst is high
        end
        rst      = 1'b0;
        in_valid = 1'b0;
        @(posedge clk);
        #1;
        compare_field("out_valid", 1'b0, out_valid);
        compare_field("route_mask", '0, route_mask);
        compare_field("route_code", '0, route_code);
        finish_test("reset");

        send_all_pairs(ALGO_XY);
        drain();
        finish_test("xy");

        repeat (200) send_random(ALGO_WEST_FIRST);
        drain();
        finish_test("west-first");

        send_all_pairs(ALGO_ODD_EVEN);
        drain();
        finish_test("odd-even");

        repeat (100) send_random(ALGO_DUATO);
        for (int n = 0; n < 4; n++) begin
            send(ALGO_DUATO, n, 3 - n, n, 3 - n); // same node
        end
        drain();
        finish_test("duato");

        for (int i = 0; i < 40; i++) begin
            send_random(route_algo_e'(i % 4));
            if (i % 7 == 6) begin
                idle(); // gap in the request stream
            end
        end
        drain();
        finish_test("throughput");

        $display("summary: %0d tests ok, %0d tests with errors", tests_ok, tests_bad);
        if (errors == 0 && tests_bad == 0) begin
            $display("Test passed");
        end
        else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- mesh_route.f
+incdir+common
+incdir+tests
common/mesh_route_pkg.sv
common/mesh_coord_if.sv
common/mesh_dir_if.sv
verilog/mesh_dir.sv
routing/xy_routing.sv
routing/west_first_routing.sv
routing/odd_even_routing.sv
routing/duato_routing.sv
verilog/mesh_route_unit.sv
tests/tb_mesh_route.sv
